//--- common/cpu_consts.svh
// CPU subsystem constants
// Boot address, word width and register file size
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// First instruction fetched after reset
`define CPU_BOOT_ADDR 32'h0000_0180

// Data and address width
`define CPU_XLEN      32

// Register file of eight words, register 0 hard-wired to zero
`define CPU_NUM_REGS  8
`define CPU_REG_AW    3

`endif

//--- common/bus_pkg.sv
// Bus types
// Words shared by the instruction and data bus ports
`default_nettype none

`include "cpu_consts.svh"

package bus_pkg;

    // Byte address
    typedef logic [`CPU_XLEN-1:0] addr_t;

    // Read and write data
    typedef logic [`CPU_XLEN-1:0] data_t;

    // One enable per byte lane
    typedef logic [`CPU_XLEN/8-1:0] be_t;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
// Instruction set definitions
// Opcodes, the register and immediate formats, and the decoded operation
`default_nettype none

`include "cpu_consts.svh"

package isa_pkg;

    // Any other value executes as a no-operation
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_ADDI = 4'h4,
        OP_LW   = 4'h5,
        OP_SW   = 4'h6,
        OP_HALT = 4'h7
    } opcode_e;

    // Register format
    typedef struct packed {
        opcode_e                               opcode;
        logic [`CPU_REG_AW-1:0]                rd;
        logic [`CPU_REG_AW-1:0]                rs1;
        logic [`CPU_REG_AW-1:0]                rs2;
        logic [`CPU_XLEN-3*`CPU_REG_AW-5:0]    unused;
    } r_fmt_t;

    // Immediate format, rd doubles as store source for SW
    typedef struct packed {
        opcode_e                               opcode;
        logic [`CPU_REG_AW-1:0]                rd;
        logic [`CPU_REG_AW-1:0]                rs1;
        logic [`CPU_XLEN-2*`CPU_REG_AW-21:0]   unused;
        logic signed [15:0]                    imm;
    } i_fmt_t;

    // Same word seen through either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR,
        ALU_LOAD,
        ALU_STORE,
        ALU_HALT,
        ALU_NOP
    } alu_op_e;

endpackage

`default_nettype wire

//--- core/instr_fetch.sv
// Instruction fetch
// Holds the PC and fetches one word per retired instruction
`default_nettype none

`include "cpu_consts.svh"

module instr_fetch (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           fetch_enable_i,
    input  logic           retire_i,
    input  logic           halt_i,
    input  logic           instr_gnt_i,
    input  logic           instr_rvalid_i,
    input  bus_pkg::data_t instr_rdata_i,
    output logic           instr_req_o,
    output bus_pkg::addr_t instr_addr_o,
    output logic           instr_valid_o,
    output bus_pkg::data_t instr_word_o
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT
    } fetch_state_e;

    fetch_state_e   state_q;
    bus_pkg::addr_t pc_q;
    logic           started_q;
    logic           halted_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= FETCH_IDLE;
            pc_q          <= `CPU_BOOT_ADDR;
            started_q     <= 1'b0;
            halted_q      <= 1'b0;
            instr_valid_o <= 1'b0;
        end else begin
            instr_valid_o <= 1'b0;
            // Halt arrives one cycle ahead of its retire
            if (halt_i) begin
                halted_q <= 1'b1;
            end
            case (state_q)
                FETCH_IDLE: begin
                    if (!started_q && fetch_enable_i) begin
                        started_q <= 1'b1;
                        state_q   <= FETCH_REQ;
                    end else if (retire_i && !halted_q) begin
                        pc_q    <= pc_q + bus_pkg::addr_t'(4);
                        state_q <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (instr_gnt_i) begin
                        state_q <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (instr_rvalid_i) begin
                        instr_valid_o <= 1'b1;
                        state_q       <= FETCH_IDLE;
                    end
                end
                default: state_q <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == FETCH_WAIT && instr_rvalid_i) begin
            instr_word_o <= instr_rdata_i;
        end
    end

    // Read-only master, so only req and addr leave this block
    assign instr_req_o  = (state_q == FETCH_REQ);
    assign instr_addr_o = pc_q;

    // Address held until the memory grants it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

`default_nettype wire

//--- core/instr_decode.sv
// Instruction decode
// Splits the word into operation, registers and immediate, one cycle
`default_nettype none

`include "cpu_consts.svh"

module instr_decode (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   instr_valid_i,
    input  bus_pkg::data_t         instr_word_i,
    input  bus_pkg::data_t         rs1_data_i,
    input  bus_pkg::data_t         rs2_data_i,
    output logic [`CPU_REG_AW-1:0] rs1_addr_o,
    output logic [`CPU_REG_AW-1:0] rs2_addr_o,
    output logic                   dec_valid_o,
    output isa_pkg::alu_op_e       dec_op_o,
    output logic [`CPU_REG_AW-1:0] dec_rd_o,
    output bus_pkg::data_t         dec_a_o,
    output bus_pkg::data_t         dec_b_o,
    output bus_pkg::data_t         dec_imm_o
);

    isa_pkg::instr_u  instr;
    isa_pkg::alu_op_e op_d;
    logic             is_i_fmt;
    bus_pkg::data_t   imm_ext;

    assign instr = instr_word_i;

    always_comb begin
        op_d     = isa_pkg::ALU_NOP;
        is_i_fmt = 1'b0;
        case (instr.r.opcode)
            isa_pkg::OP_ADD:  op_d = isa_pkg::ALU_ADD;
            isa_pkg::OP_SUB:  op_d = isa_pkg::ALU_SUB;
            isa_pkg::OP_AND:  op_d = isa_pkg::ALU_AND;
            isa_pkg::OP_XOR:  op_d = isa_pkg::ALU_XOR;
            isa_pkg::OP_ADDI: begin
                op_d     = isa_pkg::ALU_ADD;
                is_i_fmt = 1'b1;
            end
            isa_pkg::OP_LW: begin
                op_d     = isa_pkg::ALU_LOAD;
                is_i_fmt = 1'b1;
            end
            isa_pkg::OP_SW: begin
                op_d     = isa_pkg::ALU_STORE;
                is_i_fmt = 1'b1;
            end
            isa_pkg::OP_HALT: op_d = isa_pkg::ALU_HALT;
            default:          op_d = isa_pkg::ALU_NOP;
        endcase
    end

    assign imm_ext = is_i_fmt ? {{(`CPU_XLEN-16){instr.i.imm[15]}}, instr.i.imm} : '0;

    // Store data comes from the rd field
    assign rs1_addr_o = instr.r.rs1;
    assign rs2_addr_o = (instr.r.opcode == isa_pkg::OP_SW) ? instr.i.rd : instr.r.rs2;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            dec_op_o  <= op_d;
            dec_rd_o  <= instr.r.rd;
            dec_a_o   <= rs1_data_i;
            // ADDI takes the immediate as second operand
            dec_b_o   <= (op_d == isa_pkg::ALU_ADD && is_i_fmt) ? imm_ext : rs2_data_i;
            dec_imm_o <= imm_ext;
        end
    end

endmodule

`default_nettype wire

//--- core/execute_lsu.sv
// Execute and load/store unit
// One-cycle ALU, plus a data bus master for LW and SW
`default_nettype none

`include "cpu_consts.svh"

module execute_lsu (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   dec_valid_i,
    input  isa_pkg::alu_op_e       dec_op_i,
    input  logic [`CPU_REG_AW-1:0] dec_rd_i,
    input  bus_pkg::data_t         dec_a_i,
    input  bus_pkg::data_t         dec_b_i,
    input  bus_pkg::data_t         dec_imm_i,
    input  logic                   data_gnt_i,
    input  logic                   data_rvalid_i,
    input  bus_pkg::data_t         data_rdata_i,
    output logic                   data_req_o,
    output bus_pkg::addr_t         data_addr_o,
    output logic                   data_we_o,
    output bus_pkg::be_t           data_be_o,
    output bus_pkg::data_t         data_wdata_o,
    output logic                   res_valid_o,
    output logic [`CPU_REG_AW-1:0] res_rd_o,
    output bus_pkg::data_t         res_data_o,
    output logic                   res_we_o,
    output logic                   halt_o
);

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_REQ,
        LSU_WAIT
    } lsu_state_e;

    lsu_state_e     state_q;
    bus_pkg::data_t alu_res;
    bus_pkg::addr_t addr_sum;
    logic           is_mem;
    logic           start;

    always_comb begin
        case (dec_op_i)
            isa_pkg::ALU_ADD: alu_res = dec_a_i + dec_b_i;
            isa_pkg::ALU_SUB: alu_res = dec_a_i - dec_b_i;
            isa_pkg::ALU_AND: alu_res = dec_a_i & dec_b_i;
            isa_pkg::ALU_XOR: alu_res = dec_a_i ^ dec_b_i;
            default:          alu_res = '0;
        endcase
    end

    assign addr_sum = dec_a_i + dec_imm_i;
    assign is_mem   = dec_op_i inside {isa_pkg::ALU_LOAD, isa_pkg::ALU_STORE};
    assign start    = dec_valid_i && (state_q == LSU_IDLE);

    assign data_req_o = (state_q == LSU_REQ);
    // Word accesses only
    assign data_be_o  = '1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= LSU_IDLE;
            res_valid_o <= 1'b0;
            halt_o      <= 1'b0;
        end else begin
            res_valid_o <= 1'b0;
            halt_o      <= 1'b0;
            case (state_q)
                LSU_IDLE: begin
                    if (start && is_mem) begin
                        state_q <= LSU_REQ;
                    end else if (start) begin
                        res_valid_o <= 1'b1;
                        halt_o      <= (dec_op_i == isa_pkg::ALU_HALT);
                    end
                end
                LSU_REQ: begin
                    if (data_gnt_i) begin
                        state_q <= LSU_WAIT;
                    end
                end
                LSU_WAIT: begin
                    if (data_rvalid_i) begin
                        res_valid_o <= 1'b1;
                        state_q     <= LSU_IDLE;
                    end
                end
                default: state_q <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            data_addr_o  <= {addr_sum[`CPU_XLEN-1:2], 2'b00};
            data_we_o    <= (dec_op_i == isa_pkg::ALU_STORE);
            data_wdata_o <= dec_b_i;
            res_rd_o     <= dec_rd_i;
            res_data_o   <= alu_res;
            // No register write for SW, HALT and NOP
            res_we_o     <= dec_op_i inside {isa_pkg::ALU_ADD, isa_pkg::ALU_SUB,
                                             isa_pkg::ALU_AND, isa_pkg::ALU_XOR,
                                             isa_pkg::ALU_LOAD};
        end else if (state_q == LSU_WAIT && data_rvalid_i && !data_we_o) begin
            res_data_o <= data_rdata_i;
        end
    end

    // Request and payload held until granted
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
            && $stable(data_we_o) && $stable(data_wdata_o));

    // Memory answers only a granted request
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_rvalid_i |-> state_q == LSU_WAIT);

endmodule

`default_nettype wire

//--- core/result_writeback.sv
// Result writeback
// Register file, retire pulse and the sleep flag after HALT
`default_nettype none

`include "cpu_consts.svh"

module result_writeback (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   res_valid_i,
    input  logic [`CPU_REG_AW-1:0] res_rd_i,
    input  bus_pkg::data_t         res_data_i,
    input  logic                   res_we_i,
    input  logic                   halt_i,
    input  logic [`CPU_REG_AW-1:0] rs1_addr_i,
    input  logic [`CPU_REG_AW-1:0] rs2_addr_i,
    output bus_pkg::data_t         rs1_data_o,
    output bus_pkg::data_t         rs2_data_o,
    output logic                   retire_o,
    output logic                   core_sleep_o
);

    bus_pkg::data_t regs_q [`CPU_NUM_REGS];

    // Writes to register 0 are dropped
    always_ff @(posedge clk_i) begin
        if (res_valid_i && res_we_i && res_rd_i != '0) begin
            regs_q[res_rd_i] <= res_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_o     <= 1'b0;
            core_sleep_o <= 1'b0;
        end else begin
            retire_o <= res_valid_i;
            // Sleep until reset once HALT retires
            if (res_valid_i && halt_i) begin
                core_sleep_o <= 1'b1;
            end
        end
    end

    // Nothing executes once the core is asleep
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_sleep_o |-> !res_valid_i);

endmodule

`default_nettype wire

//--- design/cpu_subsystem.sv
// CPU subsystem
// Sequential core: fetch, decode, execute and writeback on two buses
`default_nettype none

`include "cpu_consts.svh"

module cpu_subsystem (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           fetch_enable_i,
    // Instruction bus
    output logic           instr_req_o,
    input  logic           instr_gnt_i,
    output bus_pkg::addr_t instr_addr_o,
    input  logic           instr_rvalid_i,
    input  bus_pkg::data_t instr_rdata_i,
    // Data bus
    output logic           data_req_o,
    input  logic           data_gnt_i,
    output bus_pkg::addr_t data_addr_o,
    output logic           data_we_o,
    output bus_pkg::be_t   data_be_o,
    output bus_pkg::data_t data_wdata_o,
    input  logic           data_rvalid_i,
    input  bus_pkg::data_t data_rdata_i,
    output logic           core_sleep_o
);

    logic                   instr_valid;
    bus_pkg::data_t         instr_word;
    logic [`CPU_REG_AW-1:0] rs1_addr;
    logic [`CPU_REG_AW-1:0] rs2_addr;
    bus_pkg::data_t         rs1_data;
    bus_pkg::data_t         rs2_data;
    logic                   dec_valid;
    isa_pkg::alu_op_e       dec_op;
    logic [`CPU_REG_AW-1:0] dec_rd;
    bus_pkg::data_t         dec_a;
    bus_pkg::data_t         dec_b;
    bus_pkg::data_t         dec_imm;
    logic                   res_valid;
    logic [`CPU_REG_AW-1:0] res_rd;
    bus_pkg::data_t         res_data;
    logic                   res_we;
    logic                   halt;
    logic                   retire;

    instr_fetch u_instr_fetch (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_enable_i (fetch_enable_i),
        .retire_i       (retire),
        .halt_i         (halt),
        .instr_gnt_i    (instr_gnt_i),
        .instr_rvalid_i (instr_rvalid_i),
        .instr_rdata_i  (instr_rdata_i),
        .instr_req_o    (instr_req_o),
        .instr_addr_o   (instr_addr_o),
        .instr_valid_o  (instr_valid),
        .instr_word_o   (instr_word)
    );

    instr_decode u_instr_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid),
        .instr_word_i  (instr_word),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .dec_valid_o   (dec_valid),
        .dec_op_o      (dec_op),
        .dec_rd_o      (dec_rd),
        .dec_a_o       (dec_a),
        .dec_b_o       (dec_b),
        .dec_imm_o     (dec_imm)
    );

    execute_lsu u_execute_lsu (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dec_valid_i   (dec_valid),
        .dec_op_i      (dec_op),
        .dec_rd_i      (dec_rd),
        .dec_a_i       (dec_a),
        .dec_b_i       (dec_b),
        .dec_imm_i     (dec_imm),
        .data_gnt_i    (data_gnt_i),
        .data_rvalid_i (data_rvalid_i),
        .data_rdata_i  (data_rdata_i),
        .data_req_o    (data_req_o),
        .data_addr_o   (data_addr_o),
        .data_we_o     (data_we_o),
        .data_be_o     (data_be_o),
        .data_wdata_o  (data_wdata_o),
        .res_valid_o   (res_valid),
        .res_rd_o      (res_rd),
        .res_data_o    (res_data),
        .res_we_o      (res_we),
        .halt_o        (halt)
    );

    result_writeback u_result_writeback (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .res_valid_i  (res_valid),
        .res_rd_i     (res_rd),
        .res_data_i   (res_data),
        .res_we_i     (res_we),
        .halt_i       (halt),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .retire_o     (retire),
        .core_sleep_o (core_sleep_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
// Testbench clock and reset
// 100 ns clock, reset held low for the first 5 cycles
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/tb_cpu_subsystem.sv
// CPU subsystem testbench
// Random program served by two bus memories, checked against an in-order model
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS   = 256;
    localparam int PROG_RANDOM = 40;
    localparam int SLEEP_LIMIT = 4000;

    logic           clk_i;
    logic           rst_n_i;
    logic           fetch_enable_i;
    logic           instr_req_o;
    logic           instr_gnt_i;
    bus_pkg::addr_t instr_addr_o;
    logic           instr_rvalid_i;
    bus_pkg::data_t instr_rdata_i;
    logic           data_req_o;
    logic           data_gnt_i;
    bus_pkg::addr_t data_addr_o;
    logic           data_we_o;
    bus_pkg::be_t   data_be_o;
    bus_pkg::data_t data_wdata_o;
    logic           data_rvalid_i;
    bus_pkg::data_t data_rdata_i;
    logic           core_sleep_o;

    bus_pkg::data_t imem [MEM_WORDS];
    bus_pkg::data_t dmem [MEM_WORDS];
    bus_pkg::data_t prog [$];

    // Model output, consumed in bus order
    bus_pkg::addr_t exp_fetch [$];
    logic           exp_we [$];
    bus_pkg::addr_t exp_addr [$];
    bus_pkg::data_t exp_wdata [$];
    int             model_stores;
    int             stores_seen;
    int             value_errs;
    int             other_errs;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    cpu_subsystem u_cpu_subsystem (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_enable_i (fetch_enable_i),
        .instr_req_o    (instr_req_o),
        .instr_gnt_i    (instr_gnt_i),
        .instr_addr_o   (instr_addr_o),
        .instr_rvalid_i (instr_rvalid_i),
        .instr_rdata_i  (instr_rdata_i),
        .data_req_o     (data_req_o),
        .data_gnt_i     (data_gnt_i),
        .data_addr_o    (data_addr_o),
        .data_we_o      (data_we_o),
        .data_be_o      (data_be_o),
        .data_wdata_o   (data_wdata_o),
        .data_rvalid_i  (data_rvalid_i),
        .data_rdata_i   (data_rdata_i),
        .core_sleep_o   (core_sleep_o)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
        value_errs++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        other_errs++;
    endtask

    // Bits 18:16 stay zero in both formats
    function automatic bus_pkg::data_t encode_instr(input isa_pkg::opcode_e op,
                                                    input logic [`CPU_REG_AW-1:0] rd,
                                                    input logic [`CPU_REG_AW-1:0] rs1,
                                                    input logic [`CPU_REG_AW-1:0] rs2,
                                                    input logic [15:0] imm);
        return {op, rd, rs1, rs2, 3'b000, imm};
    endfunction

    task automatic build_program();
        isa_pkg::opcode_e ops [7];
        bus_pkg::addr_t   pc;
        int               k;
        ops = '{isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_XOR,
                isa_pkg::OP_ADDI, isa_pkg::OP_LW, isa_pkg::OP_SW};
        // Register file has no reset, so every register gets a value first
        for (int r = 1; r < `CPU_NUM_REGS; r++) begin
            prog.push_back(encode_instr(isa_pkg::OP_ADDI, 3'(r), 3'd0, 3'd0,
                                        16'($urandom_range(0, 1020))));
        end
        while (prog.size() < PROG_RANDOM) begin
            k = $urandom_range(0, 6);
            prog.push_back(encode_instr(ops[k], 3'($urandom_range(0, 7)),
                                        3'($urandom_range(0, 7)), 3'($urandom_range(0, 7)),
                                        16'($urandom_range(0, 1020))));
        end
        // Dump every register, then sleep
        for (int r = 0; r < `CPU_NUM_REGS; r++) begin
            prog.push_back(encode_instr(isa_pkg::OP_SW, 3'(r), 3'd0, 3'd0, 16'(12'h380 + 4 * r)));
        end
        prog.push_back(encode_instr(isa_pkg::OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0));

        // Unused words are NOPs that carry their own index
        foreach (imem[i]) begin
            imem[i] = {4'hf, 20'h0, 8'(i)};
        end
        pc = `CPU_BOOT_ADDR;
        foreach (prog[n]) begin
            imem[pc[9:2]] = prog[n];
            pc = pc + 32'd4;
        end
        foreach (dmem[i]) begin
            dmem[i] = $urandom();
        end
    endtask

    task automatic run_model();
        bus_pkg::data_t regs [`CPU_NUM_REGS];
        bus_pkg::data_t mem [MEM_WORDS];
        bus_pkg::addr_t pc;
        bus_pkg::addr_t addr;
        bus_pkg::data_t w;
        bus_pkg::data_t a;
        bus_pkg::data_t b;
        bus_pkg::data_t imm;
        bus_pkg::data_t res;
        logic           wr;
        regs = '{default: '0};
        mem  = dmem;
        pc   = `CPU_BOOT_ADDR;
        foreach (prog[n]) begin
            w    = prog[n];
            a    = regs[w[24:22]];
            b    = regs[w[21:19]];
            imm  = {{16{w[15]}}, w[15:0]};
            addr = (a + imm) & ~32'h3;
            res  = '0;
            wr   = 1'b1;
            exp_fetch.push_back(pc);
            case (w[31:28])
                isa_pkg::OP_ADD:  res = a + b;
                isa_pkg::OP_SUB:  res = a - b;
                isa_pkg::OP_AND:  res = a & b;
                isa_pkg::OP_XOR:  res = a ^ b;
                isa_pkg::OP_ADDI: res = a + imm;
                isa_pkg::OP_LW: begin
                    res = mem[addr[9:2]];
                    exp_we.push_back(1'b0);
                    exp_addr.push_back(addr);
                    exp_wdata.push_back('0);
                end
                isa_pkg::OP_SW: begin
                    // Store source sits in the rd field
                    wr = 1'b0;
                    mem[addr[9:2]] = regs[w[27:25]];
                    exp_we.push_back(1'b1);
                    exp_addr.push_back(addr);
                    exp_wdata.push_back(regs[w[27:25]]);
                    model_stores++;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[27:25] != 3'd0) begin
                regs[w[27:25]] = res;
            end
            pc = pc + 32'd4;
        end
    endtask

    task automatic check_data_access(input bus_pkg::addr_t addr, input logic we,
                                     input bus_pkg::data_t wdata);
        logic           want_we;
        bus_pkg::addr_t want_addr;
        bus_pkg::data_t want_wdata;
        if (exp_addr.size() == 0) begin
            report_error("data access beyond the expected sequence");
        end else begin
            want_we    = exp_we.pop_front();
            want_addr  = exp_addr.pop_front();
            want_wdata = exp_wdata.pop_front();
            assert (we == want_we) else report_mismatch("data_we_o", 32'(we), 32'(want_we));
            assert (addr == want_addr) else report_mismatch("data_addr_o", addr, want_addr);
            if (want_we) begin
                assert (wdata == want_wdata)
                    else report_mismatch("data_wdata_o", wdata, want_wdata);
            end
        end
    endtask

    task automatic check_quiet();
        assert (!instr_req_o) else report_mismatch("instr_req_o", 32'(instr_req_o), 32'd0);
        assert (!data_req_o) else report_mismatch("data_req_o", 32'(data_req_o), 32'd0);
        assert (!core_sleep_o) else report_mismatch("core_sleep_o", 32'(core_sleep_o), 32'd0);
    endtask

    // Instruction memory
    // State 0 idle, 1 grant pending, 2 granted, 3 answer pending
    initial begin : instr_memory
        int             state;
        int             delay;
        bus_pkg::addr_t addr;
        bus_pkg::addr_t want;
        state = 0;
        delay = 0;
        addr  = '0;
        instr_gnt_i    <= 1'b0;
        instr_rvalid_i <= 1'b0;
        instr_rdata_i  <= '0;
        forever begin
            @(posedge clk_i);
            instr_gnt_i    <= 1'b0;
            instr_rvalid_i <= 1'b0;
            if (state == 2) begin
                delay = $urandom_range(1, 3);
                state = 3;
            end else if (state == 3) begin
                assert (!instr_req_o) else report_error("instruction request before rvalid");
            end
            if (state == 3) begin
                delay--;
                if (delay == 0) begin
                    instr_rvalid_i <= 1'b1;
                    instr_rdata_i  <= imem[addr[9:2]];
                    state = 0;
                end
            end else if (state == 0 && instr_req_o) begin
                addr = instr_addr_o;
                assert (fetch_enable_i) else report_error("instruction request before enable");
                if (exp_fetch.size() == 0) begin
                    report_error("instruction request after the last expected fetch");
                end else begin
                    want = exp_fetch.pop_front();
                    assert (addr == want) else report_mismatch("instr_addr_o", addr, want);
                end
                delay = $urandom_range(0, 3);
                state = 1;
            end
            if (state == 1) begin
                assert (instr_req_o) else report_error("instr_req_o dropped before gnt");
                assert (instr_addr_o == addr)
                    else report_mismatch("instr_addr_o", instr_addr_o, addr);
                if (delay == 0) begin
                    instr_gnt_i <= 1'b1;
                    state = 2;
                end else begin
                    delay--;
                end
            end
        end
    end

    // Data memory, same handshake as the instruction side
    initial begin : data_memory
        int             state;
        int             delay;
        bus_pkg::addr_t addr;
        logic           we;
        bus_pkg::data_t wdata;
        state = 0;
        delay = 0;
        addr  = '0;
        we    = 1'b0;
        wdata = '0;
        data_gnt_i    <= 1'b0;
        data_rvalid_i <= 1'b0;
        data_rdata_i  <= '0;
        forever begin
            @(posedge clk_i);
            data_gnt_i    <= 1'b0;
            data_rvalid_i <= 1'b0;
            if (state == 2) begin
                check_data_access(addr, we, wdata);
                if (we) begin
                    dmem[addr[9:2]] = wdata;
                    stores_seen++;
                end
                delay = $urandom_range(1, 3);
                state = 3;
            end else if (state == 3) begin
                assert (!data_req_o) else report_error("data request before rvalid");
            end
            if (state == 3) begin
                delay--;
                if (delay == 0) begin
                    data_rvalid_i <= 1'b1;
                    data_rdata_i  <= dmem[addr[9:2]];
                    state = 0;
                end
            end else if (state == 0 && data_req_o) begin
                addr  = data_addr_o;
                we    = data_we_o;
                wdata = data_wdata_o;
                assert (data_be_o == 4'hf)
                    else report_mismatch("data_be_o", 32'(data_be_o), 32'hf);
                delay = $urandom_range(0, 3);
                state = 1;
            end
            if (state == 1) begin
                assert (data_req_o) else report_error("data_req_o dropped before gnt");
                assert (data_addr_o == addr)
                    else report_mismatch("data_addr_o", data_addr_o, addr);
                assert (data_we_o == we)
                    else report_mismatch("data_we_o", 32'(data_we_o), 32'(we));
                assert (data_wdata_o == wdata)
                    else report_mismatch("data_wdata_o", data_wdata_o, wdata);
                if (delay == 0) begin
                    data_gnt_i <= 1'b1;
                    state = 2;
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin : stimulus
        int cycles;
        int hold;
        void'($urandom(32'h8142c60f));
        value_errs   = 0;
        other_errs   = 0;
        model_stores = 0;
        stores_seen  = 0;
        fetch_enable_i <= 1'b0;
        build_program();
        run_model();

        // Bus and sleep outputs stay low through reset
        cycles = 0;
        while (rst_n_i !== 1'b1 && cycles < 20) begin
            @(posedge clk_i);
            check_quiet();
            cycles++;
        end
        if (rst_n_i !== 1'b1) begin
            report_error("reset was never released");
        end

        // Fetch held off for a few cycles after reset
        hold = $urandom_range(2, 6);
        for (int c = 0; c < hold; c++) begin
            @(posedge clk_i);
            check_quiet();
        end
        fetch_enable_i <= 1'b1;

        cycles = 0;
        while (!core_sleep_o && cycles < SLEEP_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!core_sleep_o) begin
            report_error("timeout waiting for core_sleep_o");
        end
        assert (exp_fetch.size() == 0) else report_error("core_sleep_o rose before HALT fetch");

        for (int c = 0; c < 20; c++) begin
            @(posedge clk_i);
            assert (!instr_req_o) else report_error("instruction request after HALT");
            assert (core_sleep_o) else report_error("core_sleep_o fell before reset");
        end
        assert (stores_seen == model_stores)
            else report_mismatch("store count", stores_seen, model_stores);
        assert (exp_addr.size() == 0) else report_error("expected data accesses not issued");

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+common
common/bus_pkg.sv
common/isa_pkg.sv
core/instr_fetch.sv
core/instr_decode.sv
core/execute_lsu.sv
core/result_writeback.sv
design/cpu_subsystem.sv
bench/tb_clock_gen.sv
bench/tb_cpu_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the CPU subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cpu_subsystem -f compile.f

result=$(./obj_dir/Vtb_cpu_subsystem)
echo "$result"

if echo "$result" | grep -q '^\*\* PASS \*\*$'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
